// File: design/gcm_block_counter.sv
// counts input blocks of a frame and raises the AAD-done level,
// the GCTR data-start strobes and the all-input-done pulse
module gcm_block_counter
(
    input  logic                      i_clock,
    input  logic                      i_rst,
    input  logic                      i_enable,
    input  logic                      i_sop,
    input  logic                      i_valid_in,
    input  gcm_seq_pkg::blk_count_t   i_length_aad,
    input  gcm_seq_pkg::ptx_len_t     i_length_ptx,
    output logic                      o_aad_done,
    output gcm_seq_pkg::gctr_strobe_t o_gctr_now,
    output logic                      o_in_all_done,
    output gcm_seq_pkg::blk_count_t   o_blocks
);

    import gcm_seq_pkg::*;

    // sop qualified by enable opens a new frame
    logic       sop_now;
    logic       in_frame;
    logic       frame_q;

    // input block count
    blk_count_t count_q;
    blk_count_t count_base;
    blk_count_t run_count;
    logic       in_step;

    // frame geometry
    blk_count_t blocks;
    blk_count_t aad_plus_one;
    blk_count_t aad_plus_blk;
    logic       has_aad;
    logic       has_data;

    // strobes and their once-only flags
    logic       aad_hit;
    logic       start_pre;
    logic       start;
    logic       all_done;
    logic       aad_done_q;
    logic       start_fired_q;
    logic       all_fired_q;

    // --------------------------------------------------
    // running count
    // --------------------------------------------------

    assign sop_now  = i_enable & i_sop;
    assign in_frame = frame_q | sop_now;

    // sop cycle counts from zero and ignores the stale count of the last frame
    assign count_base = sop_now ? '0 : count_q;
    assign in_step    = i_enable & i_valid_in & ~sop_now;
    assign run_count  = count_base + blk_count_t'(in_step);

    always_ff @(posedge i_clock)
    begin
        if (i_rst || sop_now)
            count_q <= '0;
        else if (i_enable && i_valid_in)
            count_q <= count_q + blk_count_t'(1);
    end

    // stays set after the first sop so idle cycles after reset stay quiet
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            frame_q <= 1'b0;
        else if (sop_now)
            frame_q <= 1'b1;
    end

    // --------------------------------------------------
    // frame geometry
    // --------------------------------------------------

    // half-block length rounded up to whole blocks
    assign blocks       = blk_count_t'(i_length_ptx >> 1) + blk_count_t'(i_length_ptx[0]);
    assign aad_plus_one = i_length_aad + blk_count_t'(1);
    assign aad_plus_blk = i_length_aad + blocks;
    assign has_aad      = |i_length_aad;
    assign has_data     = |blocks;

    // --------------------------------------------------
    // strobes
    // --------------------------------------------------

    // empty AAD is done at sop already
    assign aad_hit = in_frame & i_enable & ~(aad_done_q & ~sop_now) &
                     (has_aad ? (run_count == i_length_aad) : sop_now);

    // warning strobe coincides with the end of the AAD
    assign start_pre = aad_hit;

    // first data block only when the plaintext is not empty
    assign start = in_frame & i_enable & has_data & ~(start_fired_q & ~sop_now) &
                   (run_count == aad_plus_one);

    // last input block of AAD and data together
    assign all_done = in_frame & i_enable & ~(all_fired_q & ~sop_now) &
                      (run_count == aad_plus_blk);

    // flags are cleared by sop and set by their own strobe
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            aad_done_q    <= 1'b0;
            start_fired_q <= 1'b0;
            all_fired_q   <= 1'b0;
        end
        else
        begin
            aad_done_q    <= aad_hit   | (aad_done_q & ~sop_now);
            start_fired_q <= start     | (start_fired_q & ~sop_now);
            all_fired_q   <= all_done  | (all_fired_q & ~sop_now);
        end
    end

    assign o_aad_done           = aad_done_q;
    assign o_gctr_now.start_pre = start_pre;
    assign o_gctr_now.start     = start;
    assign o_in_all_done        = all_done;
    assign o_blocks             = blocks;

endmodule

// File: design/gcm_cipher_tracker.sv
// counts ciphered blocks returning from GCTR in encrypt mode,
// one done pulse per frame on the last one
module gcm_cipher_tracker
(
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_enable,
    input  logic                    i_sop,
    input  logic                    i_valid_cipher,
    input  logic                    i_aad_done,
    input  logic                    i_start_pre,
    input  gcm_seq_pkg::blk_count_t i_blocks,
    output logic                    o_cipher_done
);

    import gcm_seq_pkg::*;

    logic       sop_now;
    logic       cipher_step;
    blk_count_t count_q;
    blk_count_t run_count;
    logic       start_pre_q;
    logic       done;
    logic       done_fired_q;

    // --------------------------------------------------
    // cipher block count
    // --------------------------------------------------

    assign sop_now     = i_enable & i_sop;
    assign cipher_step = i_enable & i_valid_cipher & ~sop_now;
    assign run_count   = (sop_now ? '0 : count_q) + blk_count_t'(cipher_step);

    // cleared on done, next frame starts from zero
    always_ff @(posedge i_clock)
    begin
        if (i_rst || sop_now || done)
            count_q <= '0;
        else if (i_enable && i_valid_cipher)
            count_q <= count_q + blk_count_t'(1);
    end

    // --------------------------------------------------
    // done pulse
    // --------------------------------------------------

    // start_pre one cycle late, used when there is no data at all
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            start_pre_q <= 1'b0;
        else
            start_pre_q <= i_start_pre;
    end

    // empty plaintext: no cipher block comes back
    assign done = i_aad_done & ~(done_fired_q & ~sop_now) &
                  ((|i_blocks) ? (run_count == i_blocks) : start_pre_q);

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            done_fired_q <= 1'b0;
        else
            done_fired_q <= done | (done_fired_q & ~sop_now);
    end

    assign o_cipher_done = done;

endmodule

// File: design/gcm_enable_delay.sv
// fixed delay line for the GCTR strobes, moves only on enable
// so the delay matches the AES pipeline in enabled cycles
`include "gcm_seq_defs.svh"

module gcm_enable_delay
#(
    parameter int DEPTH = `GCM_AES_LATENCY
)
(
    input  logic                      i_clock,
    input  logic                      i_rst,
    input  logic                      i_enable,
    input  gcm_seq_pkg::gctr_strobe_t i_data,
    output gcm_seq_pkg::gctr_strobe_t o_data
);

    import gcm_seq_pkg::*;

    // stage 0 takes the input, last stage drives the output
    gctr_strobe_t stage_q [DEPTH];

    // --------------------------------------------------
    // shift register
    // --------------------------------------------------

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                stage_q[i] <= '0;
            end
        end
        else if (i_enable)
        begin
            stage_q[0] <= i_data;
            for (int i = 1; i < DEPTH; i++)
            begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_data = stage_q[DEPTH-1];

endmodule

// File: design/gcm_ghash_ctrl.sv
// qualifies the GHASH input valids, places the length word
// and drives the GHASH input selector
module gcm_ghash_ctrl
(
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_sop,
    input  logic                    i_encrypt,
    input  logic                    i_valid_in,
    input  logic                    i_valid_cipher,
    input  logic                    i_aad_done,
    input  logic                    i_cipher_done,
    input  logic                    i_in_all_done,
    input  gcm_seq_pkg::blk_count_t i_length_aad,
    input  gcm_seq_pkg::ptx_len_t   i_length_ptx,
    input  gcm_seq_pkg::blk_count_t i_blocks,
    output logic                    o_ghash_sop,
    output logic                    o_ghash_valid_aad,
    output logic                    o_ghash_valid_data,
    output logic                    o_ghash_valid_length,
    output logic                    o_ghash_valid,
    output gcm_seq_pkg::ghash_sel_t o_ghash_sel
);

    import gcm_seq_pkg::*;

    logic valid_aad;
    logic valid_data;
    logic length_trig;
    logic length_trig_q;
    logic length_same;
    logic valid_length;

    // --------------------------------------------------
    // AAD and data valids
    // --------------------------------------------------

    // registered aad_done lets the last AAD block still count here
    assign valid_aad = (|i_length_aad) & ~i_aad_done & i_valid_in;

    // encrypt hashes the ciphertext from GCTR and decrypt the input
    // decrypt input during AAD belongs to the AAD valid only
    assign valid_data = i_encrypt ? i_valid_cipher : (i_valid_in & ~valid_aad);

    // --------------------------------------------------
    // length word
    // --------------------------------------------------

    // last ciphered block in encrypt and last input block in decrypt
    assign length_trig = i_encrypt ? i_cipher_done : i_in_all_done;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            length_trig_q <= 1'b0;
        else
            length_trig_q <= length_trig;
    end

    // odd half-length leaves a free slot in the trigger cycle
    // same for empty data after a non-empty AAD
    assign length_same  = i_length_ptx[0] | (~|i_blocks & |i_length_aad);
    assign valid_length = length_same ? length_trig : length_trig_q;

    // --------------------------------------------------
    // GHASH outputs
    // --------------------------------------------------

    assign o_ghash_sop          = i_sop;
    assign o_ghash_valid_aad    = valid_aad;
    assign o_ghash_valid_data   = valid_data;
    assign o_ghash_valid_length = valid_length;
    assign o_ghash_valid        = i_sop | valid_aad | valid_data | valid_length;

    // each valid sets its own selector bit
    // AAD and length meet when a decrypt frame has no data
    always_comb
    begin
        o_ghash_sel = GHASH_SEL_DATA;
        if (valid_aad)
            o_ghash_sel = o_ghash_sel | GHASH_SEL_AAD;
        if (valid_length)
            o_ghash_sel = o_ghash_sel | GHASH_SEL_LENGTH;
    end

endmodule

// File: design/gcm_seq_defs.svh
// build-time constants for the GCM control sequencer
// include wherever counter width or AES latency is needed
`ifndef GCM_SEQ_DEFS_SVH
`define GCM_SEQ_DEFS_SVH

// --------------------------------------------------
// block counting
// --------------------------------------------------

// width of block counters and of the AAD length field
// ptx length is one bit wider, in half-block units
`define GCM_NB_COUNT 10

// --------------------------------------------------
// AES pipeline
// --------------------------------------------------

// depth of the AES core in enabled cycles
// GCTR output strobes trail their source by exactly this much
`define GCM_AES_LATENCY 44

`endif

// File: design/gcm_seq_pkg.sv
// shared types for the GCM control sequencer
// compile before any RTL that names gcm_seq_pkg
package gcm_seq_pkg;

    `include "gcm_seq_defs.svh"

    // --------------------------------------------------
    // counts and lengths
    // --------------------------------------------------

    // block count, also used for the AAD length
    typedef logic [`GCM_NB_COUNT-1:0] blk_count_t;

    // plaintext length in half blocks, lsb set means a half block tail
    typedef logic [`GCM_NB_COUNT:0] ptx_len_t;

    // --------------------------------------------------
    // GCTR strobes
    // --------------------------------------------------

    // start_pre warns one block ahead, start marks the first data block
    typedef struct packed {
        logic start_pre;
        logic start;
    } gctr_strobe_t;

    // --------------------------------------------------
    // GHASH input selector
    // --------------------------------------------------

    // msb selects AAD, lsb selects the length word
    typedef logic [1:0] ghash_sel_t;

    localparam ghash_sel_t GHASH_SEL_DATA   = 2'b00;
    localparam ghash_sel_t GHASH_SEL_LENGTH = 2'b01;
    localparam ghash_sel_t GHASH_SEL_AAD    = 2'b10;

endpackage

// File: design/gcm_sequencer.sv
// top of the AES-GCM control sequencer, block counting, cipher
// tracking, GHASH control and the GCTR strobe delay
module gcm_sequencer
(
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_enable,
    input  logic                    i_sop,
    input  logic                    i_valid_in,
    input  logic                    i_valid_cipher,
    input  logic                    i_encrypt,
    input  gcm_seq_pkg::blk_count_t i_length_aad,
    input  gcm_seq_pkg::ptx_len_t   i_length_ptx,
    output logic                    o_gctr_start_pre,
    output logic                    o_gctr_start,
    output logic                    o_gctr_out_start_pre,
    output logic                    o_gctr_out_start,
    output logic                    o_ghash_sop,
    output logic                    o_ghash_valid_aad,
    output logic                    o_ghash_valid_data,
    output logic                    o_ghash_valid_length,
    output logic                    o_ghash_valid,
    output gcm_seq_pkg::ghash_sel_t o_ghash_sel
);

    import gcm_seq_pkg::*;

    logic         aad_done;
    logic         in_all_done;
    logic         cipher_done;
    blk_count_t   blocks;
    gctr_strobe_t gctr_now;
    gctr_strobe_t gctr_out;

    // --------------------------------------------------
    // input side
    // --------------------------------------------------

    gcm_block_counter u_block_counter
    (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_enable      (i_enable),
        .i_sop         (i_sop),
        .i_valid_in    (i_valid_in),
        .i_length_aad  (i_length_aad),
        .i_length_ptx  (i_length_ptx),
        .o_aad_done    (aad_done),
        .o_gctr_now    (gctr_now),
        .o_in_all_done (in_all_done),
        .o_blocks      (blocks)
    );

    // encrypt return path
    gcm_cipher_tracker u_cipher_tracker
    (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_enable       (i_enable),
        .i_sop          (i_sop),
        .i_valid_cipher (i_valid_cipher),
        .i_aad_done     (aad_done),
        .i_start_pre    (gctr_now.start_pre),
        .i_blocks       (blocks),
        .o_cipher_done  (cipher_done)
    );

    // --------------------------------------------------
    // GHASH and GCTR outputs
    // --------------------------------------------------

    gcm_ghash_ctrl u_ghash_ctrl
    (
        .i_clock              (i_clock),
        .i_rst                (i_rst),
        .i_sop                (i_sop),
        .i_encrypt            (i_encrypt),
        .i_valid_in           (i_valid_in),
        .i_valid_cipher       (i_valid_cipher),
        .i_aad_done           (aad_done),
        .i_cipher_done        (cipher_done),
        .i_in_all_done        (in_all_done),
        .i_length_aad         (i_length_aad),
        .i_length_ptx         (i_length_ptx),
        .i_blocks             (blocks),
        .o_ghash_sop          (o_ghash_sop),
        .o_ghash_valid_aad    (o_ghash_valid_aad),
        .o_ghash_valid_data   (o_ghash_valid_data),
        .o_ghash_valid_length (o_ghash_valid_length),
        .o_ghash_valid        (o_ghash_valid),
        .o_ghash_sel          (o_ghash_sel)
    );

    // both strobes share one line, depth is the AES latency
    gcm_enable_delay u_enable_delay
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_enable (i_enable),
        .i_data   (gctr_now),
        .o_data   (gctr_out)
    );

    assign o_gctr_start_pre     = gctr_now.start_pre;
    assign o_gctr_start         = gctr_now.start;
    assign o_gctr_out_start_pre = gctr_out.start_pre;
    assign o_gctr_out_start     = gctr_out.start;

endmodule

// File: gcm_sequencer.f
+incdir+design
design/gcm_seq_pkg.sv
design/gcm_block_counter.sv
design/gcm_cipher_tracker.sv
design/gcm_ghash_ctrl.sv
design/gcm_enable_delay.sv
design/gcm_sequencer.sv
verif/tb_gcm_sequencer.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the gcm_sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_gcm_sequencer \
    -f gcm_sequencer.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: verif/gcm_sequencer_cases.txt
// one frame per line, all values hex, a line of ffff ends the list
// aad_len ptx_half_len encrypt gap exp_aad_valids exp_data_valids exp_length_valids
0002 0008 0001 0000 0002 0004 0001
0002 0008 0000 0000 0002 0004 0001
0003 0007 0001 0001 0003 0004 0001
0003 0007 0000 0001 0003 0004 0001
0000 0006 0001 0002 0000 0003 0001
0000 0005 0000 0002 0000 0003 0001
0004 0000 0001 0000 0004 0000 0001
0004 0000 0000 0003 0004 0000 0001
0000 0000 0001 0000 0000 0000 0001
0000 0000 0000 0001 0000 0000 0001
0001 0001 0001 0003 0001 0001 0001
0001 0001 0000 0000 0001 0001 0001
0000 0001 0001 0001 0000 0001 0001
0005 000a 0000 0002 0005 0005 0001
0006 000b 0001 0003 0006 0006 0001
0010 0014 0001 0002 0010 000a 0001
0001 0002 0000 0003 0001 0001 0001
0002 0000 0001 0001 0002 0000 0001
ffff

// File: verif/tb_gcm_sequencer.sv
// testbench for gcm_sequencer driving frames read from verif/gcm_sequencer_cases.txt
// GCTR strobes and GHASH valids are checked every cycle against a reference model
`include "gcm_seq_defs.svh"

module tb_gcm_sequencer;

    import gcm_seq_pkg::*;

    localparam int         LAT       = `GCM_AES_LATENCY;
    localparam int         MAX_CASES = 32;
    localparam int         COLS      = 7;
    localparam int         FRAME_GAP = 6;
    localparam int         LEN_WAIT  = 8;
    localparam int         RNG_SEED  = 5;

    // DUT inputs
    logic       i_clock;
    logic       i_rst;
    logic       i_enable;
    logic       i_sop;
    logic       i_valid_in;
    logic       i_valid_cipher;
    logic       i_encrypt;
    blk_count_t i_length_aad;
    ptx_len_t   i_length_ptx;

    // DUT outputs
    logic       o_gctr_start_pre;
    logic       o_gctr_start;
    logic       o_gctr_out_start_pre;
    logic       o_gctr_out_start;
    logic       o_ghash_sop;
    logic       o_ghash_valid_aad;
    logic       o_ghash_valid_data;
    logic       o_ghash_valid_length;
    logic       o_ghash_valid;
    ghash_sel_t o_ghash_sel;

    // expected source events driven together with the stimulus
    logic exp_pre;
    logic exp_start;
    logic in_last;
    logic cip_last;

    // reference model state
    logic [LAT-1:0] pre_pipe;
    logic [LAT-1:0] start_pipe;
    logic           pre_prev;
    logic           trig_prev;
    logic           trig;
    logic           len_same;
    logic           exp_len;
    logic           exp_aad;
    logic           exp_data;
    logic           started = 1'b0;
    int             blocks_now;
    int             in_cnt;
    int             aad_cnt;
    int             data_cnt;
    int             len_cnt;

    logic [15:0] case_mem [MAX_CASES*COLS];
    int          num_cases;
    int          max_len;
    int          frames_done;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;

    gcm_sequencer i_dut
    (
        .i_clock              (i_clock),
        .i_rst                (i_rst),
        .i_enable             (i_enable),
        .i_sop                (i_sop),
        .i_valid_in           (i_valid_in),
        .i_valid_cipher       (i_valid_cipher),
        .i_encrypt            (i_encrypt),
        .i_length_aad         (i_length_aad),
        .i_length_ptx         (i_length_ptx),
        .o_gctr_start_pre     (o_gctr_start_pre),
        .o_gctr_start         (o_gctr_start),
        .o_gctr_out_start_pre (o_gctr_out_start_pre),
        .o_gctr_out_start     (o_gctr_out_start),
        .o_ghash_sop          (o_ghash_sop),
        .o_ghash_valid_aad    (o_ghash_valid_aad),
        .o_ghash_valid_data   (o_ghash_valid_data),
        .o_ghash_valid_length (o_ghash_valid_length),
        .o_ghash_valid        (o_ghash_valid),
        .o_ghash_sel          (o_ghash_sel)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    // --------------------------------------------------
    // failure reporting
    // --------------------------------------------------

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else fail_run($sformatf("ERROR %s: got 0x%0h expected 0x%0h at cycle %0d",
                                name, got, exp, cycle_count));
    endtask

    // whole run bounded by the case lengths
    always @(posedge i_clock)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
            fail_run($sformatf("timeout, run passed its limit of %0d cycles", cycle_limit));
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    // no valids while enable is low
    task automatic idle_cycle(input logic en);
        @(posedge i_clock);
        i_enable       <= en;
        i_sop          <= 1'b0;
        i_valid_in     <= 1'b0;
        i_valid_cipher <= 1'b0;
        exp_pre        <= 1'b0;
        exp_start      <= 1'b0;
        in_last        <= 1'b0;
        cip_last       <= 1'b0;
    endtask

    // random idle cycles with enable dropped in about half of them
    task automatic gap_cycles(input int density);
        while (int'($urandom_range(7)) < density)
        begin
            idle_cycle(1'($urandom_range(1)));
        end
    endtask

    task automatic drive_slot(input logic sop, input logic vin, input logic vcip,
                              input logic pre, input logic start, input logic inl,
                              input logic cipl);
        @(posedge i_clock);
        i_enable       <= 1'b1;
        i_sop          <= sop;
        i_valid_in     <= vin;
        i_valid_cipher <= vcip;
        exp_pre        <= pre;
        exp_start      <= start;
        in_last        <= inl;
        cip_last       <= cipl;
    endtask

    task automatic run_frame(input int row);
        int aad;
        int ptx;
        int enc;
        int gap;
        int blocks;
        int total;
        int waited;
        aad    = int'(case_mem[row*COLS]);
        ptx    = int'(case_mem[row*COLS+1]);
        enc    = int'(case_mem[row*COLS+2]);
        gap    = int'(case_mem[row*COLS+3]);
        blocks = (ptx + 1) / 2;
        total  = aad + blocks;
        gap_cycles(gap);
        // sop carries start_pre when there is no AAD
        drive_slot(1'b1, 1'b0, 1'b0, aad == 0, 1'b0, total == 0, 1'b0);
        i_length_aad <= blk_count_t'(aad);
        i_length_ptx <= ptx_len_t'(ptx);
        i_encrypt    <= enc[0];
        // AAD blocks then data blocks
        for (int k = 1; k <= total; k++)
        begin
            gap_cycles(gap);
            drive_slot(1'b0, 1'b1, 1'b0, aad != 0 && k == aad,
                       blocks != 0 && k == aad + 1, k == total, 1'b0);
        end
        // ciphered blocks coming back from GCTR
        for (int k = 1; enc != 0 && k <= blocks; k++)
        begin
            gap_cycles(gap);
            drive_slot(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, k == blocks);
        end
        waited = 0;
        idle_cycle(1'b1);
        while (len_cnt == 0 && waited < LEN_WAIT)
        begin
            idle_cycle(1'b1);
            waited++;
        end
        assert (len_cnt != 0)
        else fail_run($sformatf("length word never came in frame %0d", row));
        // quiet tail catches any repeated strobe
        repeat (FRAME_GAP) idle_cycle(1'b1);
        check_value("o_ghash_valid_aad count", 16'(aad_cnt), case_mem[row*COLS+4]);
        check_value("o_ghash_valid_data count", 16'(data_cnt), case_mem[row*COLS+5]);
        check_value("o_ghash_valid_length count", 16'(len_cnt), case_mem[row*COLS+6]);
        frames_done++;
    endtask

    // --------------------------------------------------
    // reference model sampled mid-cycle
    // --------------------------------------------------

    always @(negedge i_clock)
    begin
        if (i_rst)
        begin
            pre_pipe   = '0;
            start_pipe = '0;
            pre_prev   = 1'b0;
            trig_prev  = 1'b0;
        end
        else
        begin
            if (i_enable && i_sop)
            begin
                started  = 1'b1;
                in_cnt   = 0;
                aad_cnt  = 0;
                data_cnt = 0;
                len_cnt  = 0;
            end
            blocks_now = (int'(i_length_ptx) + 1) / 2;
            // the first AAD-length input blocks of a frame are AAD
            exp_aad  = i_valid_in && (in_cnt < int'(i_length_aad));
            exp_data = i_encrypt ? i_valid_cipher : (i_valid_in && !exp_aad);
            // empty encrypt data triggers one cycle after start_pre
            if (i_encrypt)
                trig = (blocks_now != 0) ? cip_last : pre_prev;
            else
                trig = in_last;
            len_same = i_length_ptx[0] || (blocks_now == 0 && i_length_aad != 0);
            exp_len  = len_same ? trig : trig_prev;

            if (!started)
                check_value("outputs before sop", 16'({o_gctr_start_pre, o_gctr_start,
                            o_gctr_out_start_pre, o_gctr_out_start, o_ghash_sop,
                            o_ghash_valid_aad, o_ghash_valid_data, o_ghash_valid_length,
                            o_ghash_valid, o_ghash_sel}), 16'h0);
            check_value("o_gctr_start_pre", 16'(o_gctr_start_pre), 16'(exp_pre));
            check_value("o_gctr_start", 16'(o_gctr_start), 16'(exp_start));
            check_value("o_gctr_out_start_pre", 16'(o_gctr_out_start_pre),
                        16'(pre_pipe[LAT-1]));
            check_value("o_gctr_out_start", 16'(o_gctr_out_start), 16'(start_pipe[LAT-1]));
            check_value("o_ghash_sop", 16'(o_ghash_sop), 16'(i_sop));
            check_value("o_ghash_valid_aad", 16'(o_ghash_valid_aad), 16'(exp_aad));
            check_value("o_ghash_valid_data", 16'(o_ghash_valid_data), 16'(exp_data));
            check_value("o_ghash_valid_length", 16'(o_ghash_valid_length), 16'(exp_len));
            check_value("o_ghash_valid", 16'(o_ghash_valid),
                        16'(i_sop | exp_aad | exp_data | exp_len));
            // upper selector bit for AAD and lower bit for the length word
            check_value("o_ghash_sel", 16'(o_ghash_sel), 16'({exp_aad, exp_len}));

            aad_cnt  = aad_cnt + int'(o_ghash_valid_aad);
            data_cnt = data_cnt + int'(o_ghash_valid_data);
            len_cnt  = len_cnt + int'(o_ghash_valid_length);
            if (i_enable && i_valid_in && !i_sop)
                in_cnt = in_cnt + 1;
            // AES latency counts enabled cycles only
            if (i_enable)
            begin
                pre_pipe   = {pre_pipe[LAT-2:0], exp_pre};
                start_pipe = {start_pipe[LAT-2:0], exp_start};
            end
            pre_prev  = exp_pre;
            trig_prev = trig;
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial
    begin
        void'($urandom(RNG_SEED));
        i_rst          = 1'b1;
        i_enable       = 1'b0;
        i_sop          = 1'b0;
        i_valid_in     = 1'b0;
        i_valid_cipher = 1'b0;
        i_encrypt      = 1'b0;
        i_length_aad   = '0;
        i_length_ptx   = '0;
        exp_pre        = 1'b0;
        exp_start      = 1'b0;
        in_last        = 1'b0;
        cip_last       = 1'b0;
        num_cases      = 0;
        max_len        = 0;
        frames_done    = 0;
        // all ones in the first column ends the list
        for (int i = 0; i < MAX_CASES*COLS; i++)
        begin
            case_mem[i] = 16'hffff;
        end
        $readmemh("verif/gcm_sequencer_cases.txt", case_mem);
        while (num_cases < MAX_CASES && case_mem[num_cases*COLS] != 16'hffff)
        begin
            // input blocks plus returning cipher blocks
            max_len = (int'(case_mem[num_cases*COLS]) + int'(case_mem[num_cases*COLS+1]) + 1
                       > max_len) ? int'(case_mem[num_cases*COLS])
                       + int'(case_mem[num_cases*COLS+1]) + 1 : max_len;
            num_cases++;
        end
        assert (num_cases > 0)
        else fail_run("no frames found in the case file");
        cycle_limit = num_cases * (64 + max_len * 4);

        repeat (4) @(posedge i_clock);
        i_rst <= 1'b0;
        repeat (8) idle_cycle(1'b1);
        for (int row = 0; row < num_cases; row++)
        begin
            run_frame(row);
        end
        // let the last delayed strobes drain
        repeat (LAT + 8) idle_cycle(1'b1);

        if (frames_done == num_cases)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
            fail_run("not every frame in the case file was run");
    end

endmodule
